/* common/dot11_pkg.sv */
package dot11_pkg;

    ////////////////////////////////////////////////////////////
    // header sizes and check lengths
    ////////////////////////////////////////////////////////////
    localparam int L_SIG_BYTES  = 3;
    localparam int HT_SIG_BYTES = 6;
    localparam int HT_CRC_BITS  = 34;

    // x^8+x^2+x+1, shifted msb first
    localparam logic [7:0] HT_CRC8_POLY = 8'h07;

    // 04C11DB7 reversed, for the lsb-first register
    localparam logic [31:0] CRC32_POLY_REFL = 32'hEDB8_8320;
    // register value after data plus a correct fcs
    localparam logic [31:0] FCS_RESIDUE     = 32'hDEBB_20E3;

    ////////////////////////////////////////////////////////////
    // stream and header types
    ////////////////////////////////////////////////////////////

    // ht only meaningful together with sop
    typedef struct packed {
        logic       ht;
        logic       sop;
        logic [7:0] data;
    } rx_byte_t;

    typedef enum logic [3:0] {
        E_OK,
        E_PARITY_FAIL,
        E_WRONG_RSVD,
        E_WRONG_TAIL,
        E_UNSUPPORTED_RATE,
        E_WRONG_CRC,
        E_UNSUPPORTED_MCS,
        E_UNSUPPORTED_CBW,
        E_HT_WRONG_RSVD,
        E_UNSUPPORTED_STBC,
        E_UNSUPPORTED_FEC,
        E_UNSUPPORTED_SPATIAL,
        E_HT_WRONG_TAIL,
        E_WRONG_FCS
    } status_e;

    // rate sits in the low bits, first on air
    typedef struct packed {
        logic [5:0]  tail;
        logic        parity;
        logic [11:0] length;
        logic        reserved;
        logic [3:0]  rate;
    } legacy_sig_t;

    // ht-sig2 in the upper 24 bits, ht-sig1 below
    typedef struct packed {
        logic [5:0]  tail;
        logic [7:0]  crc;
        logic [1:0]  num_ext;
        logic        sgi;
        logic        fec;
        logic [1:0]  stbc;
        logic        aggregation;
        logic        reserved;
        logic        not_sounding;
        logic        smoothing;
        logic [15:0] length;
        logic        cbw;
        logic [6:0]  mcs;
    } ht_sig_t;

    // rate[7] marks an ht mcs
    typedef struct packed {
        logic [7:0]  rate;
        logic [15:0] length;
        logic        ht;
        logic        aggr;
        logic        sgi;
    } pkt_info_t;

    typedef struct packed {
        logic    done;
        logic    ok;
        status_e status;
    } hdr_result_t;

endpackage

/* header/ht_sig_crc8.sv */
module ht_sig_crc8
    import dot11_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  logic       clear_i,
    input  logic       bit_i,
    input  logic       bit_valid_i,
    output logic [7:0] crc_o
);

    logic [7:0] crc_q;
    logic       feedback;

    assign feedback = bit_i ^ crc_q[7];

    always_ff @(posedge clock) begin
        if (reset || clear_i) begin
            crc_q <= 8'hff;
        end else if (bit_valid_i) begin
            crc_q <= {crc_q[6:0], 1'b0} ^ (feedback ? HT_CRC8_POLY : 8'h00);
        end
    end

    // c7 goes out first and inverted, so it lands in bit 0
    always_comb begin
        for (int i = 0; i < 8; i++) begin
            crc_o[i] = ~crc_q[7 - i];
        end
    end

endmodule

/* header/header_decoder.sv */
module header_decoder
    import dot11_pkg::*;
(
    input  logic        clock,
    input  logic        reset,
    input  logic [7:0]  hdr_byte_i,
    input  logic        hdr_valid_i,
    input  logic        is_ht_i,
    output pkt_info_t   info_o,
    output hdr_result_t result_o
);

    typedef enum logic [1:0] {
        S_COLLECT,
        S_SETUP,
        S_CRC,
        S_HT_CHECK
    } state_e;

    state_e      state;
    logic [3:0]  byte_cnt;
    logic [5:0]  bit_cnt;
    legacy_sig_t lsig;
    legacy_sig_t lsig_next;
    ht_sig_t     hsig;
    logic        last_byte;
    status_e     l_status;
    status_e     h_status;
    logic [7:0]  crc_calc;

    ////////////////////////////////////////////////////////////
    // field checks, first failure wins
    ////////////////////////////////////////////////////////////
    function automatic status_e check_lsig(input legacy_sig_t s);
        status_e st;
        // even parity over rate, reserved and length
        if (^s[17:0])
            st = E_PARITY_FAIL;
        else if (s.reserved)
            st = E_WRONG_RSVD;
        else if (s.tail != '0)
            st = E_WRONG_TAIL;
        else if (!s.rate[3])
            st = E_UNSUPPORTED_RATE;
        else
            st = E_OK;
        return st;
    endfunction

    function automatic status_e check_ht(input ht_sig_t s, input logic [7:0] crc);
        status_e st;
        if (crc != s.crc)
            st = E_WRONG_CRC;
        else if (s.mcs > 7'd7)
            st = E_UNSUPPORTED_MCS;
        else if (s.cbw)
            st = E_UNSUPPORTED_CBW;
        else if (!s.reserved)
            st = E_HT_WRONG_RSVD;
        else if (s.stbc != '0)
            st = E_UNSUPPORTED_STBC;
        else if (s.fec)
            st = E_UNSUPPORTED_FEC;
        else if (s.num_ext != '0)
            st = E_UNSUPPORTED_SPATIAL;
        else if (s.tail != '0)
            st = E_HT_WRONG_TAIL;
        else
            st = E_OK;
        return st;
    endfunction

    // lsig with the incoming byte already shifted in
    assign lsig_next = (byte_cnt < 4'(L_SIG_BYTES)) ?
        legacy_sig_t'({hdr_byte_i, lsig[23:8]}) : lsig;
    assign last_byte = hdr_valid_i && (is_ht_i ?
        (byte_cnt == 4'(L_SIG_BYTES + HT_SIG_BYTES - 1)) : (byte_cnt == 4'(L_SIG_BYTES - 1)));
    assign l_status  = check_lsig(lsig_next);
    assign h_status  = check_ht(hsig, crc_calc);

    ht_sig_crc8 crc0 (
        .clock       (clock),
        .reset       (reset),
        .clear_i     (state == S_SETUP),
        .bit_i       (hsig[bit_cnt]),
        .bit_valid_i (state == S_CRC),
        .crc_o       (crc_calc)
    );

    always_ff @(posedge clock) begin
        if (reset) begin
            state    <= S_COLLECT;
            byte_cnt <= '0;
            bit_cnt  <= '0;
            result_o <= '0;
        end else begin
            result_o.done <= 1'b0;
            case (state)
                S_COLLECT: begin
                    if (hdr_valid_i) begin
                        byte_cnt <= byte_cnt + 4'd1;
                    end
                    // a bad l-sig ends an ht header without the crc run
                    if (last_byte) begin
                        byte_cnt <= '0;
                        if (is_ht_i && l_status == E_OK) begin
                            state <= S_SETUP;
                        end else begin
                            result_o <= '{done: 1'b1, ok: (l_status == E_OK), status: l_status};
                        end
                    end
                end
                S_SETUP: begin
                    bit_cnt <= '0;
                    state   <= S_CRC;
                end
                S_CRC: begin
                    bit_cnt <= bit_cnt + 6'd1;
                    if (bit_cnt == 6'(HT_CRC_BITS - 1)) begin
                        state <= S_HT_CHECK;
                    end
                end
                default: begin
                    result_o <= '{done: 1'b1, ok: (h_status == E_OK), status: h_status};
                    state    <= S_COLLECT;
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // header registers, lsb byte first
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clock) begin
        if (hdr_valid_i) begin
            lsig <= lsig_next;
            if (byte_cnt >= 4'(L_SIG_BYTES)) begin
                hsig <= {hdr_byte_i, hsig[47:8]};
            end
        end
        if (last_byte) begin
            info_o <= '{rate: {4'd0, lsig_next.rate}, length: {4'd0, lsig_next.length},
                        ht: 1'b0, aggr: 1'b0, sgi: 1'b0};
        end else if (state == S_HT_CHECK) begin
            info_o <= '{rate: {1'b1, hsig.mcs}, length: hsig.length,
                        ht: 1'b1, aggr: hsig.aggregation, sgi: hsig.sgi};
        end
    end

    // control holds its pops until the verdict
    a_no_byte_in_check: assert property (@(posedge clock) disable iff (reset)
        (state != S_COLLECT) |-> !hdr_valid_i)
        else $error("header byte during ht-sig check");

endmodule

/* verilog/rx_byte_fifo.sv */
module rx_byte_fifo
    import dot11_pkg::*;
#(
    parameter int FIFO_DEPTH = 8
) (
    input  logic     clock,
    input  logic     reset,
    input  logic     push_valid_i,
    input  rx_byte_t push_i,
    input  logic     pop_i,
    output rx_byte_t head_o,
    output logic     head_valid_o,
    output logic     credit_o
);

    localparam int ADDR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W  = $clog2(FIFO_DEPTH + 1);

    rx_byte_t          mem [FIFO_DEPTH];
    logic [ADDR_W-1:0] wr_ptr;
    logic [ADDR_W-1:0] rd_ptr;
    logic [CNT_W-1:0]  count;
    logic              do_pop;

    function automatic logic [ADDR_W-1:0] next_ptr(input logic [ADDR_W-1:0] p);
        return (p == ADDR_W'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign head_o       = mem[rd_ptr];
    assign head_valid_o = (count != '0);
    assign do_pop       = pop_i && head_valid_o;

    always_ff @(posedge clock) begin
        if (reset) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            credit_o <= 1'b0;
        end else begin
            // every byte taken out hands one credit back
            credit_o <= do_pop;
            if (push_valid_i) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            count <= count + CNT_W'(push_valid_i) - CNT_W'(do_pop);
        end
    end

    always_ff @(posedge clock) begin
        if (push_valid_i) begin
            mem[wr_ptr] <= push_i;
        end
    end

    // sender outran its credits
    a_no_overflow: assert property (@(posedge clock) disable iff (reset)
        push_valid_i |-> (count < CNT_W'(FIFO_DEPTH)))
        else $error("push into full byte fifo");

endmodule

/* verilog/rx_control.sv */
module rx_control
    import dot11_pkg::*;
(
    input  logic        clock,
    input  logic        reset,
    input  rx_byte_t    head_i,
    input  logic        head_valid_i,
    output logic        pop_o,
    output logic [7:0]  hdr_byte_o,
    output logic        hdr_valid_o,
    output logic        is_ht_o,
    input  hdr_result_t result_i,
    input  pkt_info_t   info_i,
    output logic        fcs_clear_o,
    output logic [7:0]  data_o,
    output logic        data_valid_o,
    input  logic        fcs_match_i,
    output logic        hdr_strobe_o,
    output pkt_info_t   pkt_info_o,
    output logic        hdr_ok_o,
    output logic        fcs_strobe_o,
    output logic        fcs_ok_o,
    output status_e     status_o
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_HEADER,
        S_HEADER_WAIT,
        S_DATA,
        S_FCS_REPORT,
        S_DISCARD
    } state_e;

    state_e      state;
    logic        ht_q;
    logic [3:0]  hdr_cnt;
    logic [3:0]  hdr_last;
    logic [15:0] pay_cnt;
    logic [15:0] pay_len;
    logic        sop_seen;

    assign sop_seen = head_valid_i && head_i.sop;
    assign hdr_last = ht_q ? 4'(L_SIG_BYTES + HT_SIG_BYTES - 1) : 4'(L_SIG_BYTES - 1);

    ////////////////////////////////////////////////////////////
    // byte routing
    ////////////////////////////////////////////////////////////

    // no pops while the header is checked so credits stall
    always_comb begin
        case (state)
            S_IDLE, S_HEADER, S_DATA: pop_o = head_valid_i;
            S_DISCARD:                pop_o = head_valid_i && !head_i.sop;
            default:                  pop_o = 1'b0;
        endcase
    end

    assign hdr_byte_o  = head_i.data;
    assign hdr_valid_o = pop_o && ((state == S_HEADER) || (state == S_IDLE && head_i.sop));
    assign is_ht_o     = ht_q;
    assign fcs_clear_o = (state == S_IDLE) && sop_seen;

    ////////////////////////////////////////////////////////////
    // packet fsm
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clock) begin
        if (reset) begin
            state        <= S_IDLE;
            ht_q         <= 1'b0;
            hdr_cnt      <= '0;
            pay_cnt      <= '0;
            data_valid_o <= 1'b0;
            hdr_strobe_o <= 1'b0;
            hdr_ok_o     <= 1'b0;
            fcs_strobe_o <= 1'b0;
            fcs_ok_o     <= 1'b0;
            status_o     <= E_OK;
        end else begin
            data_valid_o <= 1'b0;
            hdr_strobe_o <= 1'b0;
            fcs_strobe_o <= 1'b0;
            case (state)
                // stray bytes outside a packet are dropped
                S_IDLE: begin
                    if (sop_seen) begin
                        ht_q    <= head_i.ht;
                        hdr_cnt <= 4'd1;
                        state   <= S_HEADER;
                    end
                end
                S_HEADER: begin
                    if (head_valid_i) begin
                        hdr_cnt <= hdr_cnt + 4'd1;
                        if (hdr_cnt == hdr_last) begin
                            state <= S_HEADER_WAIT;
                        end
                    end
                end
                S_HEADER_WAIT: begin
                    if (result_i.done) begin
                        hdr_strobe_o <= 1'b1;
                        hdr_ok_o     <= result_i.ok;
                        status_o     <= result_i.status;
                        pay_cnt      <= '0;
                        if (!result_i.ok) begin
                            state <= S_DISCARD;
                        end else if (info_i.length == '0) begin
                            state <= S_FCS_REPORT;
                        end else begin
                            state <= S_DATA;
                        end
                    end
                end
                S_DATA: begin
                    if (head_valid_i) begin
                        data_valid_o <= 1'b1;
                        pay_cnt      <= pay_cnt + 16'd1;
                        if (pay_cnt == pay_len - 16'd1) begin
                            state <= S_FCS_REPORT;
                        end
                    end
                end
                // last byte is on data_o now and the checker includes it
                S_FCS_REPORT: begin
                    fcs_strobe_o <= 1'b1;
                    fcs_ok_o     <= fcs_match_i;
                    status_o     <= fcs_match_i ? E_OK : E_WRONG_FCS;
                    state        <= S_IDLE;
                end
                S_DISCARD: begin
                    if (sop_seen) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == S_DATA && head_valid_i) begin
            data_o <= head_i.data;
        end
        if (state == S_HEADER_WAIT && result_i.done) begin
            pkt_info_o <= info_i;
            pay_len    <= info_i.length;
        end
    end

    // payload stays within the header length
    a_data_in_data_state: assert property (@(posedge clock) disable iff (reset)
        data_valid_o |-> ($past(state) == S_DATA) && ($past(pay_cnt) < $past(pay_len)))
        else $error("payload byte outside the data state or beyond the header length");

    // a packet start is only taken in idle
    a_pop_with_head: assert property (@(posedge clock) disable iff (reset)
        pop_o |-> head_valid_i && ((state == S_IDLE) || !head_i.sop))
        else $error("pop from an empty fifo or of a packet start inside a packet");

endmodule

/* verilog/fcs_crc32.sv */
module fcs_crc32
    import dot11_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  logic       fcs_clear_i,
    input  logic [7:0] data_i,
    input  logic       data_valid_i,
    output logic       fcs_match_o
);

    logic [31:0] crc_q;
    logic [31:0] crc_next;

    // reflected crc-32, one byte lsb first
    function automatic logic [31:0] crc32_byte(input logic [31:0] crc, input logic [7:0] data);
        logic [31:0] c;
        c = crc ^ {24'd0, data};
        for (int i = 0; i < 8; i++) begin
            c = c[0] ? ((c >> 1) ^ CRC32_POLY_REFL) : (c >> 1);
        end
        return c;
    endfunction

    assign crc_next = data_valid_i ? crc32_byte(crc_q, data_i) : crc_q;

    // covers the byte arriving this cycle too
    assign fcs_match_o = (crc_next == FCS_RESIDUE);

    always_ff @(posedge clock) begin
        if (reset || fcs_clear_i) begin
            crc_q <= '1;
        end else begin
            crc_q <= crc_next;
        end
    end

endmodule

/* verilog/dot11_rx.sv */
module dot11_rx
    import dot11_pkg::*;
#(
    parameter int FIFO_DEPTH = 8
) (
    input  logic        clock,
    input  logic        reset,
    input  logic        byte_valid_i,
    input  rx_byte_t    byte_i,
    output logic        credit_o,
    output logic [7:0]  data_o,
    output logic        data_valid_o,
    output logic        hdr_strobe_o,
    output pkt_info_t   pkt_info_o,
    output logic        hdr_ok_o,
    output logic        fcs_strobe_o,
    output logic        fcs_ok_o,
    output status_e     status_o
);

    rx_byte_t    head;
    logic        head_valid;
    logic        pop;
    logic [7:0]  hdr_byte;
    logic        hdr_valid;
    logic        is_ht;
    hdr_result_t hdr_result;
    pkt_info_t   hdr_info;
    logic        fcs_clear;
    logic        fcs_match;

    rx_byte_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) fifo0 (
        .clock        (clock),
        .reset        (reset),
        .push_valid_i (byte_valid_i),
        .push_i       (byte_i),
        .pop_i        (pop),
        .head_o       (head),
        .head_valid_o (head_valid),
        .credit_o     (credit_o)
    );

    header_decoder hdr0 (
        .clock       (clock),
        .reset       (reset),
        .hdr_byte_i  (hdr_byte),
        .hdr_valid_i (hdr_valid),
        .is_ht_i     (is_ht),
        .info_o      (hdr_info),
        .result_o    (hdr_result)
    );

    rx_control ctrl0 (
        .clock        (clock),
        .reset        (reset),
        .head_i       (head),
        .head_valid_i (head_valid),
        .pop_o        (pop),
        .hdr_byte_o   (hdr_byte),
        .hdr_valid_o  (hdr_valid),
        .is_ht_o      (is_ht),
        .result_i     (hdr_result),
        .info_i       (hdr_info),
        .fcs_clear_o  (fcs_clear),
        .data_o       (data_o),
        .data_valid_o (data_valid_o),
        .fcs_match_i  (fcs_match),
        .hdr_strobe_o (hdr_strobe_o),
        .pkt_info_o   (pkt_info_o),
        .hdr_ok_o     (hdr_ok_o),
        .fcs_strobe_o (fcs_strobe_o),
        .fcs_ok_o     (fcs_ok_o),
        .status_o     (status_o)
    );

    // checker sees the same bytes that leave the receiver
    fcs_crc32 fcs0 (
        .clock        (clock),
        .reset        (reset),
        .fcs_clear_i  (fcs_clear),
        .data_i       (data_o),
        .data_valid_i (data_valid_o),
        .fcs_match_o  (fcs_match)
    );

endmodule

/* bench/tb_dot11_rx.sv */
module tb_dot11_rx
    import dot11_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int FIFO_DEPTH = 8;
    localparam int MAX_BEATS  = 4096;
    localparam int MAX_PKTS   = 64;

    // injected faults with at most one per packet
    localparam int F_NONE    = 0;
    localparam int F_PAYLOAD = 1;
    localparam int F_PARITY  = 2;
    localparam int F_RSVD    = 3;
    localparam int F_TAIL    = 4;
    localparam int F_RATE    = 5;
    localparam int F_HT_CRC  = 6;
    localparam int F_HT_MCS  = 7;

    logic      clock;
    logic      reset;
    logic      byte_valid_i;
    rx_byte_t  byte_i;
    logic      credit_o;
    logic [7:0] data_o;
    logic      data_valid_o;
    logic      hdr_strobe_o;
    pkt_info_t pkt_info_o;
    logic      hdr_ok_o;
    logic      fcs_strobe_o;
    logic      fcs_ok_o;
    status_e   status_o;

    // stimulus and expected results built before the run
    rx_byte_t    stream [MAX_BEATS];
    logic [7:0]  exp_data [MAX_BEATS];
    logic        exp_hdr_ok [MAX_PKTS];
    status_e     exp_hdr_status [MAX_PKTS];
    pkt_info_t   exp_info [MAX_PKTS];
    logic        exp_fcs_ok [MAX_PKTS];
    int          exp_data_end [MAX_PKTS];
    int          n_beats = 0;
    int          n_data = 0;
    int          n_hdr = 0;
    int          n_fcs = 0;
    int          len_sum = 0;
    int          watchdog_cycles = 0;
    logic        build_done = 1'b0;

    // progress through the DUT responses
    int          hdr_idx;
    int          data_idx;
    int          fcs_idx;
    int          in_cnt;
    int          back_cnt;
    int          sent_cnt = 0;
    logic        payload_open;

    int          hdr_errors = 0;
    int          data_errors = 0;
    int          fcs_errors = 0;
    int          credit_errors = 0;

    dot11_rx #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) dut0 (
        .clock        (clock),
        .reset        (reset),
        .byte_valid_i (byte_valid_i),
        .byte_i       (byte_i),
        .credit_o     (credit_o),
        .data_o       (data_o),
        .data_valid_o (data_valid_o),
        .hdr_strobe_o (hdr_strobe_o),
        .pkt_info_o   (pkt_info_o),
        .hdr_ok_o     (hdr_ok_o),
        .fcs_strobe_o (fcs_strobe_o),
        .fcs_ok_o     (fcs_ok_o),
        .status_o     (status_o)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    ////////////////////////////////////////////////////////////
    // reference crcs
    ////////////////////////////////////////////////////////////

    // ht-sig crc-8 with bit 0 of the field first
    function automatic logic [7:0] ht_crc8(input logic [33:0] bits);
        logic [7:0] c;
        logic [7:0] out;
        logic       fb;
        c = 8'hff;
        for (int i = 0; i < 34; i++) begin
            fb = bits[i] ^ c[7];
            c = {c[6:0], 1'b0};
            if (fb) begin
                c = c ^ 8'h07;
            end
        end
        // sent inverted with c7 first
        for (int i = 0; i < 8; i++) begin
            out[i] = ~c[7 - i];
        end
        return out;
    endfunction

    function automatic logic [31:0] crc32_update(input logic [31:0] crc, input logic [7:0] b);
        logic [31:0] c;
        logic        fb;
        c = crc;
        for (int i = 0; i < 8; i++) begin
            fb = c[0] ^ b[i];
            c = c >> 1;
            if (fb) begin
                c = c ^ 32'hEDB8_8320;
            end
        end
        return c;
    endfunction

    ////////////////////////////////////////////////////////////
    // packet generation
    ////////////////////////////////////////////////////////////
    task automatic push_beat(input logic [7:0] b, input logic sop, input logic ht);
        stream[n_beats] = '{ht: ht, sop: sop, data: b};
        n_beats++;
    endtask

    task automatic build_packet(input logic ht, input int fault);
        int          len;
        int          flip;
        logic [3:0]  rate;
        logic [11:0] l_len;
        logic        rsvd;
        logic [5:0]  tail;
        logic [23:0] lsig;
        logic [6:0]  mcs;
        logic        sgi;
        logic        aggr;
        logic [47:0] hsig;
        logic [7:0]  body [64];
        logic [31:0] crc;
        status_e     st;
        pkt_info_t   info;

        len   = int'($urandom_range(40, 5));
        rate  = ht ? 4'b1011 : (4'b1000 | 4'($urandom_range(7, 0)));
        l_len = ht ? 12'($urandom_range(400, 20)) : 12'(len);
        rsvd  = (fault == F_RSVD);
        tail  = (fault == F_TAIL) ? 6'($urandom_range(63, 1)) : 6'd0;
        if (fault == F_RATE) begin
            rate[3] = 1'b0;
        end
        // even parity over rate, reserved and length
        lsig = {tail, ^{l_len, rsvd, rate}, l_len, rsvd, rate};
        if (fault == F_PARITY) begin
            lsig[17] = ~lsig[17];
        end

        mcs  = (fault == F_HT_MCS) ? 7'd9 : 7'($urandom_range(7, 0));
        sgi  = 1'($urandom_range(1, 0));
        aggr = 1'($urandom_range(1, 0));
        hsig = '0;
        hsig[33:0]  = {2'b00, sgi, 1'b0, 2'b00, aggr, 1'b1, 1'b1, 1'b0, 16'(len), 1'b0, mcs};
        hsig[41:34] = ht_crc8(hsig[33:0]);
        if (fault == F_HT_CRC) begin
            flip = int'($urandom_range(33, 0));
            hsig[flip] = ~hsig[flip];
        end

        // payload then fcs lsb first
        crc = 32'hffff_ffff;
        for (int i = 0; i < len - 4; i++) begin
            body[i] = 8'($urandom_range(255, 0));
            crc = crc32_update(crc, body[i]);
        end
        crc = ~crc;
        for (int i = 0; i < 4; i++) begin
            body[len - 4 + i] = crc[8*i +: 8];
        end
        if (fault == F_PAYLOAD) begin
            flip = int'($urandom_range(len - 5, 0));
            body[flip] = ~body[flip];
        end

        case (fault)
            F_PARITY: st = E_PARITY_FAIL;
            F_RSVD:   st = E_WRONG_RSVD;
            F_TAIL:   st = E_WRONG_TAIL;
            F_RATE:   st = E_UNSUPPORTED_RATE;
            F_HT_CRC: st = E_WRONG_CRC;
            F_HT_MCS: st = E_UNSUPPORTED_MCS;
            default:  st = E_OK;
        endcase
        info.ht   = ht;
        info.rate = ht ? {1'b1, mcs} : {4'd0, rate};
        info.length = ht ? 16'(len) : {4'd0, l_len};
        info.aggr = ht ? aggr : 1'b0;
        info.sgi  = ht ? sgi : 1'b0;

        for (int i = 0; i < 3; i++) begin
            push_beat(lsig[8*i +: 8], i == 0, ht && (i == 0));
        end
        if (ht) begin
            for (int i = 0; i < 6; i++) begin
                push_beat(hsig[8*i +: 8], 1'b0, 1'b0);
            end
        end
        for (int i = 0; i < len; i++) begin
            push_beat(body[i], 1'b0, 1'b0);
        end

        exp_hdr_ok[n_hdr]     = (st == E_OK);
        exp_hdr_status[n_hdr] = st;
        exp_info[n_hdr]       = info;
        n_hdr++;
        if (st == E_OK) begin
            for (int i = 0; i < len; i++) begin
                exp_data[n_data] = body[i];
                n_data++;
            end
            exp_fcs_ok[n_fcs]   = (fault != F_PAYLOAD);
            exp_data_end[n_fcs] = n_data;
            n_fcs++;
        end
        len_sum += len;
    endtask

    task automatic build_tests();
        for (int i = 0; i < 3; i++) begin
            build_packet(1'b0, F_NONE);
        end
        build_packet(1'b0, F_PAYLOAD);
        build_packet(1'b0, F_NONE);
        // each bad signal field is followed by a clean packet
        for (int f = F_PARITY; f <= F_RATE; f++) begin
            build_packet(1'b0, f);
            build_packet(1'b0, F_NONE);
        end
        build_packet(1'b1, F_NONE);
        build_packet(1'b1, F_NONE);
        build_packet(1'b1, F_HT_CRC);
        build_packet(1'b0, F_NONE);
        build_packet(1'b1, F_HT_MCS);
        build_packet(1'b1, F_NONE);
        for (int i = 0; i < 8; i++) begin
            build_packet(1'($urandom_range(1, 0)), F_NONE);
        end
    endtask

    // sends with random gaps and never beyond the held credits
    task automatic drive_stream();
        int gap;
        for (int i = 0; i < n_beats; i++) begin
            gap = int'($urandom_range(2, 0));
            while (gap > 0 || (sent_cnt - back_cnt) >= FIFO_DEPTH) begin
                byte_valid_i <= 1'b0;
                if (gap > 0) begin
                    gap--;
                end
                @(posedge clock);
            end
            byte_valid_i <= 1'b1;
            byte_i       <= stream[i];
            sent_cnt++;
            @(posedge clock);
        end
        byte_valid_i <= 1'b0;
    endtask

    ////////////////////////////////////////////////////////////
    // response tracking and checks
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clock) begin
        if (reset) begin
            hdr_idx      <= 0;
            data_idx     <= 0;
            fcs_idx      <= 0;
            in_cnt       <= 0;
            back_cnt     <= 0;
            payload_open <= 1'b0;
        end else begin
            if (hdr_strobe_o) begin
                hdr_idx      <= hdr_idx + 1;
                payload_open <= hdr_ok_o;
            end
            if (data_valid_o) begin
                data_idx <= data_idx + 1;
            end
            if (fcs_strobe_o) begin
                fcs_idx      <= fcs_idx + 1;
                payload_open <= 1'b0;
            end
            if (byte_valid_i) begin
                in_cnt <= in_cnt + 1;
            end
            if (credit_o) begin
                back_cnt <= back_cnt + 1;
            end
        end
    end

    a_hdr_verdict: assert property (@(posedge clock) disable iff (reset)
        hdr_strobe_o |-> (hdr_idx < n_hdr) && (hdr_ok_o == exp_hdr_ok[hdr_idx])
            && (status_o == exp_hdr_status[hdr_idx]))
        else begin
            hdr_errors++;
            $display("error at %0t ns: header %0d gave ok %0b status %s, expected ok %0b %s",
                $time, hdr_idx, hdr_ok_o, status_o.name(), exp_hdr_ok[hdr_idx],
                exp_hdr_status[hdr_idx].name());
        end

    a_hdr_info: assert property (@(posedge clock) disable iff (reset)
        (hdr_strobe_o && hdr_ok_o) |-> (pkt_info_o == exp_info[hdr_idx]))
        else begin
            hdr_errors++;
            $display("error at %0t ns: header %0d info %h, expected %h",
                $time, hdr_idx, pkt_info_o, exp_info[hdr_idx]);
        end

    a_data_in_packet: assert property (@(posedge clock) disable iff (reset)
        data_valid_o |-> payload_open && (data_idx < exp_data_end[fcs_idx]))
        else begin
            data_errors++;
            $display("a payload byte came out where no accepted packet expects one");
        end

    a_data_value: assert property (@(posedge clock) disable iff (reset)
        data_valid_o |-> (data_o == exp_data[data_idx]))
        else begin
            data_errors++;
            $display("error at %0t ns: payload byte %0d is %h, expected %h",
                $time, data_idx, data_o, exp_data[data_idx]);
        end

    a_fcs_verdict: assert property (@(posedge clock) disable iff (reset)
        fcs_strobe_o |-> (fcs_idx < n_fcs) && (fcs_ok_o == exp_fcs_ok[fcs_idx])
            && (status_o == (exp_fcs_ok[fcs_idx] ? E_OK : E_WRONG_FCS)))
        else begin
            fcs_errors++;
            $display("error at %0t ns: fcs %0d gave ok %0b status %s, expected ok %0b",
                $time, fcs_idx, fcs_ok_o, status_o.name(), exp_fcs_ok[fcs_idx]);
        end

    a_fcs_byte_count: assert property (@(posedge clock) disable iff (reset)
        fcs_strobe_o |-> (data_idx == exp_data_end[fcs_idx]))
        else begin
            data_errors++;
            $display("error at %0t ns: %0d payload bytes before fcs %0d, expected %0d",
                $time, data_idx, fcs_idx, exp_data_end[fcs_idx]);
        end

    // a credit only comes back for a byte already sent
    a_credit_after_byte: assert property (@(posedge clock) disable iff (reset)
        credit_o |-> (back_cnt < in_cnt))
        else begin
            credit_errors++;
            $display("the DUT returned a credit with no byte outstanding");
        end

    initial begin
        wait (build_done);
        repeat (watchdog_cycles) @(posedge clock);
        $display("timeout after %0d cycles, the DUT did not finish all packets",
            watchdog_cycles);
        $display("tests failed");
        $finish;
    end

    initial begin
        int total;
        reset        = 1'b1;
        byte_valid_i = 1'b0;
        byte_i       = '0;
        void'($urandom(32'h3e54_3e0b));
        build_tests();
        watchdog_cycles = len_sum * 40 + 2000;
        build_done = 1'b1;

        repeat (8) @(posedge clock);
        reset <= 1'b0;
        @(posedge clock);
        drive_stream();
        while (hdr_idx != n_hdr || fcs_idx != n_fcs) begin
            @(posedge clock);
        end
        repeat (20) @(posedge clock);

        // every byte sent must have come back as a credit
        assert ((back_cnt == in_cnt) && (in_cnt == n_beats))
        else begin
            credit_errors++;
            $display("error at %0t ns: %0d credits back for %0d bytes, %0d beats planned",
                $time, back_cnt, in_cnt, n_beats);
        end

        total = hdr_errors + data_errors + fcs_errors + credit_errors;
        $display("errors: header %0d, data %0d, fcs %0d, credit %0d",
            hdr_errors, data_errors, fcs_errors, credit_errors);
        if (total == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* filelist.f */
common/dot11_pkg.sv
header/ht_sig_crc8.sv
header/header_decoder.sv
verilog/rx_byte_fifo.sv
verilog/rx_control.sv
verilog/fcs_crc32.sv
verilog/dot11_rx.sv
bench/tb_dot11_rx.sv

/* Makefile */
# Verilator build and run for the dot11 receiver back end

VERILATOR ?= verilator
TOP       ?= tb_dot11_rx
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0 -Wno-fatal
FAIL_MSG  := tests failed

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
